// File: rtl/mem_pkg.sv
// Shared types and constants for the banked test memory
// Every RTL block imports this package by wildcard in its header
// Holds the request and response message layouts and the address decode

package mem_pkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int NUM_BANKS  = 4;
	localparam int BANK_WORDS = 64;
	localparam int HALF_WORDS = BANK_WORDS / 2;
	localparam int OPAQUE_W   = 8;
	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 32;

	// Address field widths
	// Byte offset is ignored by the banks
	localparam int OFFSET_W   = 2;
	localparam int BANK_SEL_W = $clog2(NUM_BANKS);
	localparam int INDEX_W    = $clog2(HALF_WORDS);
	localparam int UNUSED_W   = ADDR_W - 1 - INDEX_W - BANK_SEL_W - OFFSET_W;

	// Request type, value 2 left unused
	typedef enum logic [2:0] {
		MEM_READ    = 3'd0,
		MEM_WRITE   = 3'd1,
		MEM_AMO_ADD = 3'd3,
		MEM_AMO_AND = 3'd4,
		MEM_AMO_OR  = 3'd5
	} mem_type_e;

	// Low word address bits pick the bank so neighbours interleave
	typedef struct packed {
		logic [UNUSED_W-1:0]   unused;
		logic                  part;
		logic [INDEX_W-1:0]    index;
		logic [BANK_SEL_W-1:0] bank;
		logic [OFFSET_W-1:0]   offset;
	} mem_addr_fields_t;

	// Same 16 bits seen flat or decoded
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		mem_addr_fields_t  fields;
	} mem_addr_u;

	typedef struct packed {
		mem_type_e           mtype;
		logic [OPAQUE_W-1:0] opaque;
		mem_addr_u           addr;
		logic [DATA_W-1:0]   data;
		logic                domain;
	} mem_req_t;

	typedef struct packed {
		mem_type_e           mtype;
		logic [OPAQUE_W-1:0] opaque;
		logic [DATA_W-1:0]   data;
		logic                domain;
		logic                denied;
	} mem_resp_t;

endpackage

// File: rtl/mem_chan_if.sv
// Valid/ready channels between the router, the banks and the merger
// The source side drives valid and payload, the destination drives ready
// A beat moves on a rising edge where valid and ready are both high

`timescale 1ns/1ps

// ------------------------------
// Request channel
// ------------------------------
interface mem_req_ch import mem_pkg::*;;

	logic     valid;
	logic     ready;
	mem_req_t payload;

	// Sender holds valid and payload steady until accepted
	modport src (
		output valid,
		output payload,
		input  ready
	);

	modport dst (
		input  valid,
		input  payload,
		output ready
	);

endinterface

// ------------------------------
// Response channel
// ------------------------------
interface mem_resp_ch import mem_pkg::*;;

	logic      valid;
	logic      ready;
	mem_resp_t payload;

	modport src (
		output valid,
		output payload,
		input  ready
	);

	modport dst (
		input  valid,
		input  payload,
		output ready
	);

endinterface

// File: rtl/mem_req_router.sv
// Request router in front of the memory banks
// Steers each request to one bank by the bank field of its word address
// Purely combinational, the upstream ready is the selected bank's ready

`timescale 1ns/1ps

module mem_req_router import mem_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      req_val_i,
	output logic      req_rdy_o,
	input  mem_req_t  req_i,
	mem_req_ch.src    bank_o [NUM_BANKS]
);

	logic [BANK_SEL_W-1:0] sel;
	logic [NUM_BANKS-1:0]  bank_val;
	logic [NUM_BANKS-1:0]  bank_rdy;

	// Bank number sits just above the byte offset
	assign sel = req_i.addr.fields.bank;

	// ------------------------------
	// Per bank fan out
	// ------------------------------
	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_port
		// Payload goes to every bank while only one sees valid
		assign bank_val[g]       = req_val_i && (sel == BANK_SEL_W'(g));
		assign bank_o[g].valid   = bank_val[g];
		assign bank_o[g].payload = req_i;
		assign bank_rdy[g]       = bank_o[g].ready;
	end

	// Back-pressure from the target bank only
	assign req_rdy_o = bank_rdy[sel];

	// Only the addressed bank sees a pending request
	a_one_bank: assert property (
		@(posedge clk) disable iff (!reset)
		$onehot0(bank_val) && (req_val_i == (|bank_val))
	);

endmodule

// File: rtl/mem_bank.sv
// One bank of the test memory, public half and secure half
// Registered input, array access in the next cycle, one-entry output buffer
// Handles read, write and the atomics add, and, or, plus a clear input

`timescale 1ns/1ps

module mem_bank import mem_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   clear_i,
	mem_req_ch.dst req,
	mem_resp_ch.src resp
);

	// Input register and output buffer
	mem_req_t  req_q;
	logic      req_full;
	mem_resp_t resp_q;
	logic      resp_full;
	mem_resp_t resp_d;

	// Storage split statically by the part bit
	logic [DATA_W-1:0] pub_mem [HALF_WORDS];
	logic [DATA_W-1:0] sec_mem [HALF_WORDS];

	logic               accept;
	logic               process;
	logic               resp_drain;
	logic [INDEX_W-1:0] idx;
	logic               is_sec;
	logic               denied;
	logic               do_store;
	logic [DATA_W-1:0]  old_word;
	logic [DATA_W-1:0]  new_word;

	// ------------------------------
	// Handshake
	// ------------------------------
	assign resp_drain = resp_full && resp.ready;
	// Held request moves on when the buffer has room this cycle
	assign process    = req_full && (!resp_full || resp_drain);
	assign req.ready  = !req_full || process;
	assign accept     = req.valid && req.ready;

	// ------------------------------
	// Access check and data path
	// ------------------------------
	assign idx      = req_q.addr.fields.index;
	assign is_sec   = req_q.addr.fields.part;
	// Public domain may not touch the secure half
	assign denied   = is_sec && !req_q.domain;
	assign old_word = is_sec ? sec_mem[idx] : pub_mem[idx];

	always_comb begin
		new_word = old_word;
		do_store = 1'b1;
		case (req_q.mtype)
			MEM_WRITE:   new_word = req_q.data;
			MEM_AMO_ADD: new_word = old_word + req_q.data;
			MEM_AMO_AND: new_word = old_word & req_q.data;
			MEM_AMO_OR:  new_word = old_word | req_q.data;
			default:     do_store = 1'b0;
		endcase
		// Denied accesses leave the array alone
		if (denied)
			do_store = 1'b0;
	end

	// Writes echo their data, reads and atomics return the old word
	always_comb begin
		resp_d.mtype  = req_q.mtype;
		resp_d.opaque = req_q.opaque;
		resp_d.domain = req_q.domain;
		resp_d.denied = denied;
		if (denied)
			resp_d.data = '0;
		else if (req_q.mtype == MEM_WRITE)
			resp_d.data = req_q.data;
		else
			resp_d.data = old_word;
	end

	// ------------------------------
	// State
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset) begin
			req_full  <= 1'b0;
			resp_full <= 1'b0;
		end else begin
			if (accept)
				req_full <= 1'b1;
			else if (process)
				req_full <= 1'b0;
			if (process)
				resp_full <= 1'b1;
			else if (resp_drain)
				resp_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_q <= req.payload;
		if (process)
			resp_q <= resp_d;
	end

	// Clear wins over a store on the same edge
	always_ff @(posedge clk) begin
		if (clear_i) begin
			for (int i = 0; i < HALF_WORDS; i++) begin
				pub_mem[i] <= '0;
				sec_mem[i] <= '0;
			end
		end else if (process && do_store) begin
			if (is_sec)
				sec_mem[idx] <= new_word;
			else
				pub_mem[idx] <= new_word;
		end
	end

	assign resp.valid   = resp_full;
	assign resp.payload = resp_q;

	// A stalled response stays put until the merger takes it
	a_resp_hold: assert property (
		@(posedge clk) disable iff (!reset)
		resp.valid && !resp.ready |=> resp.valid && $stable(resp.payload)
	);

	a_denied_zero: assert property (
		@(posedge clk) disable iff (!reset)
		resp.valid && resp.payload.denied |-> resp.payload.data == '0
	);

endmodule

// File: rtl/mem_resp_merge.sv
// Round-robin merger of the bank response channels
// Grants one valid bank per cycle into a single output register
// The search starts at the bank after the last one granted

`timescale 1ns/1ps

module mem_resp_merge import mem_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	mem_resp_ch.dst   bank_i [NUM_BANKS],
	output logic      resp_val_o,
	input  logic      resp_rdy_i,
	output mem_resp_t resp_o
);

	logic [NUM_BANKS-1:0]  bank_val;
	logic [NUM_BANKS-1:0]  grant;
	mem_resp_t             bank_msg [NUM_BANKS];
	logic [BANK_SEL_W-1:0] last_q;
	logic [BANK_SEL_W-1:0] pick_idx;
	logic                  pick_found;
	logic                  can_load;
	logic                  out_full;
	mem_resp_t             out_q;

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_port
		assign bank_val[g]     = bank_i[g].valid;
		assign bank_msg[g]     = bank_i[g].payload;
		assign bank_i[g].ready = grant[g];
	end

	// Output register empty or emptying this cycle
	assign can_load = !out_full || resp_rdy_i;

	// ------------------------------
	// Round-robin pick
	// ------------------------------
	always_comb begin
		logic [BANK_SEL_W-1:0] cand;
		pick_found = 1'b0;
		pick_idx   = last_q;
		for (int i = 1; i <= NUM_BANKS; i++) begin
			// Wraps back to last_q on the final step
			cand = last_q + BANK_SEL_W'(i);
			if (!pick_found && bank_val[cand]) begin
				pick_found = 1'b1;
				pick_idx   = cand;
			end
		end
	end

	assign grant = (pick_found && can_load) ? (NUM_BANKS'(1) << pick_idx) : '0;

	always_ff @(posedge clk) begin
		if (!reset) begin
			out_full <= 1'b0;
			// Bank 0 gets first turn
			last_q   <= BANK_SEL_W'(NUM_BANKS - 1);
		end else begin
			if (|grant) begin
				out_full <= 1'b1;
				last_q   <= pick_idx;
			end else if (resp_rdy_i)
				out_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (|grant)
			out_q <= bank_msg[pick_idx];
	end

	assign resp_val_o = out_full;
	assign resp_o     = out_q;

	// One grant at a time and only to a bank that offers a response
	a_grant_valid: assert property (
		@(posedge clk) disable iff (!reset)
		$onehot0(grant) && ((grant & ~bank_val) == '0)
	);

endmodule

// File: rtl/mem_subsys_top.sv
// Top level of the banked test memory subsystem
// Plain request and response ports, packed here into the message structs
// Router, four banks in a generate loop, then the response merger

`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
	// Control
	input  logic                clk,
	input  logic                reset,
	input  logic                clear_i,
	// Request
	input  logic                req_val_i,
	output logic                req_rdy_o,
	input  logic [2:0]          req_type_i,
	input  logic [OPAQUE_W-1:0] req_opaque_i,
	input  logic [ADDR_W-1:0]   req_addr_i,
	input  logic [DATA_W-1:0]   req_data_i,
	input  logic                req_domain_i,
	// Response
	output logic                resp_val_o,
	input  logic                resp_rdy_i,
	output logic [2:0]          resp_type_o,
	output logic [OPAQUE_W-1:0] resp_opaque_o,
	output logic [DATA_W-1:0]   resp_data_o,
	output logic                resp_domain_o,
	output logic                resp_denied_o
);

	mem_req_t  req_s;
	mem_resp_t resp_s;

	// One request and one response channel per bank
	mem_req_ch  req_ch  [NUM_BANKS] ();
	mem_resp_ch resp_ch [NUM_BANKS] ();

	// ------------------------------
	// Port packing
	// ------------------------------
	assign req_s.mtype     = mem_type_e'(req_type_i);
	assign req_s.opaque    = req_opaque_i;
	assign req_s.addr.flat = req_addr_i;
	assign req_s.data      = req_data_i;
	assign req_s.domain    = req_domain_i;

	assign resp_type_o   = resp_s.mtype;
	assign resp_opaque_o = resp_s.opaque;
	assign resp_data_o   = resp_s.data;
	assign resp_domain_o = resp_s.domain;
	assign resp_denied_o = resp_s.denied;

	mem_req_router i_mem_req_router (
		.clk       (clk),
		.reset     (reset),
		.req_val_i (req_val_i),
		.req_rdy_o (req_rdy_o),
		.req_i     (req_s),
		.bank_o    (req_ch)
	);

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		mem_bank i_mem_bank (
			.clk     (clk),
			.reset   (reset),
			.clear_i (clear_i),
			.req     (req_ch[g]),
			.resp    (resp_ch[g])
		);
	end

	mem_resp_merge i_mem_resp_merge (
		.clk        (clk),
		.reset      (reset),
		.bank_i     (resp_ch),
		.resp_val_o (resp_val_o),
		.resp_rdy_i (resp_rdy_i),
		.resp_o     (resp_s)
	);

endmodule

// File: bench/tb_mem_subsys.sv
// Testbench for the banked test memory subsystem
// Requests and expected responses come from bench/mem_testdata.txt
// Responses are matched by opaque tag under random back-pressure

`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*;;

	localparam int CLK_HALF    = 10;
	localparam int DRV_DLY     = 2;
	localparam int RST_CYCLES  = 10;
	localparam int RDY_LIMIT   = 200;
	localparam int DRAIN_LIMIT = 2000;
	localparam int NUM_TAGS    = 2 ** OPAQUE_W;

	logic                clk = 1'b0;
	logic                reset;
	logic                clear_i;
	logic                req_val_i;
	logic                req_rdy_o;
	logic [2:0]          req_type_i;
	logic [OPAQUE_W-1:0] req_opaque_i;
	logic [ADDR_W-1:0]   req_addr_i;
	logic [DATA_W-1:0]   req_data_i;
	logic                req_domain_i;
	logic                resp_val_o;
	logic                resp_rdy_i;
	logic [2:0]          resp_type_o;
	logic [OPAQUE_W-1:0] resp_opaque_o;
	logic [DATA_W-1:0]   resp_data_o;
	logic                resp_domain_o;
	logic                resp_denied_o;

	// Expected response per opaque tag
	logic [DATA_W-1:0] exp_data   [NUM_TAGS];
	logic              exp_denied [NUM_TAGS];
	logic              exp_domain [NUM_TAGS];
	logic [2:0]        exp_type   [NUM_TAGS];
	// Sent and returned counts per tag
	int tag_sent [NUM_TAGS] = '{default: 0};
	int tag_recv [NUM_TAGS] = '{default: 0};

	int     sent_count   = 0;
	int     recv_count   = 0;
	int     val_errors   = 0;
	int     other_errors = 0;
	int     mon_val_err  = 0;
	int     mon_other    = 0;
	logic   timed_out    = 1'b0;
	integer seed         = 32'hc513;

	mem_subsys_top i_mem_subsys_top (.*);

	always #(CLK_HALF) clk = ~clk;

	// Random back-pressure with ready about three cycles in four
	initial begin
		resp_rdy_i = 1'b0;
		forever begin
			@(posedge clk);
			#(DRV_DLY);
			resp_rdy_i = (($random(seed) & 3) != 0);
		end
	end

	// ------------------------------
	// Response monitor
	// ------------------------------
	// A beat seen at the falling edge moves on the next rising edge
	always @(negedge clk) begin : monitor
		logic [OPAQUE_W-1:0] tag;
		tag = resp_opaque_o;
		if (reset && resp_val_o && resp_rdy_i) begin
			if (tag_recv[tag] >= tag_sent[tag]) begin
				$display("ERROR at %0t ns: response with opaque %h not outstanding",
					$time, tag);
				mon_other++;
			end else begin
				if (resp_data_o !== exp_data[tag]) begin
					$display("FAILED at %0t ns: resp_data_o (opaque %h) expected %h, got %h",
						$time, tag, exp_data[tag], resp_data_o);
					mon_val_err++;
				end
				if (resp_denied_o !== exp_denied[tag]) begin
					$display("FAILED at %0t ns: resp_denied_o (opaque %h) expected %b, got %b",
						$time, tag, exp_denied[tag], resp_denied_o);
					mon_val_err++;
				end
				if (resp_domain_o !== exp_domain[tag]) begin
					$display("FAILED at %0t ns: resp_domain_o (opaque %h) expected %b, got %b",
						$time, tag, exp_domain[tag], resp_domain_o);
					mon_val_err++;
				end
				if (resp_type_o !== exp_type[tag]) begin
					$display("FAILED at %0t ns: resp_type_o (opaque %h) expected %h, got %h",
						$time, tag, exp_type[tag], resp_type_o);
					mon_val_err++;
				end
			end
			tag_recv[tag] = tag_recv[tag] + 1;
			recv_count++;
		end
	end

	// ------------------------------
	// Driver tasks
	// ------------------------------
	// Called just after a rising edge, returns at the same point
	task automatic send_request(input logic [2:0] rtype, input logic [OPAQUE_W-1:0] tag,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data, input logic dom,
		input logic [DATA_W-1:0] edata, input logic eden);
		int   cycles;
		logic done;
		cycles       = 0;
		done         = 1'b0;
		req_type_i   = rtype;
		req_opaque_i = tag;
		req_addr_i   = addr;
		req_data_i   = data;
		req_domain_i = dom;
		req_val_i    = 1'b1;
		while (!done && !timed_out) begin
			@(negedge clk);
			if (req_rdy_o) begin
				// Accepted on the coming edge
				exp_data[tag]   = edata;
				exp_denied[tag] = eden;
				exp_domain[tag] = dom;
				exp_type[tag]   = rtype;
				tag_sent[tag]   = tag_sent[tag] + 1;
				sent_count++;
				done = 1'b1;
			end else begin
				cycles++;
				if (cycles >= RDY_LIMIT) begin
					$display("ERROR at %0t ns: request %h never accepted, req_rdy_o stuck low",
						$time, tag);
					other_errors++;
					timed_out = 1'b1;
				end
			end
			@(posedge clk);
			#(DRV_DLY);
		end
		req_val_i = 1'b0;
	endtask

	// Wait until every response sent so far has come back
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (sent_count != recv_count && !timed_out) begin
			@(posedge clk);
			#(DRV_DLY);
			cycles++;
			if (cycles >= DRAIN_LIMIT) begin
				$display("ERROR at %0t ns: %0d responses still outstanding after timeout",
					$time, sent_count - recv_count);
				other_errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic pulse_clear();
		clear_i = 1'b1;
		@(posedge clk);
		#(DRV_DLY);
		clear_i = 1'b0;
	endtask

	task automatic report_and_finish();
		int lost;
		lost = 0;
		for (int i = 0; i < NUM_TAGS; i++) begin
			if (tag_sent[i] != tag_recv[i]) begin
				$display("ERROR: opaque %h sent %0d times, answered %0d times",
					i, tag_sent[i], tag_recv[i]);
				lost++;
			end
		end
		$display("Checked %0d responses: %0d wrong values, %0d other errors",
			recv_count, val_errors + mon_val_err, other_errors + mon_other + lost);
		if (val_errors + mon_val_err + other_errors + mon_other + lost == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin : main
		int          fd;
		int          n;
		int          rc;
		string       line;
		logic [31:0] f_type, f_tag, f_addr, f_data, f_dom, f_exp, f_den, f_wait;
		reset        = 1'b0;
		clear_i      = 1'b0;
		req_val_i    = 1'b0;
		req_type_i   = 3'd0;
		req_opaque_i = '0;
		req_addr_i   = '0;
		req_data_i   = '0;
		req_domain_i = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#(DRV_DLY);
		reset = 1'b1;

		// Idle state straight out of reset
		if (resp_val_o !== 1'b0) begin
			$display("FAILED at %0t ns: resp_val_o expected 0, got %b", $time, resp_val_o);
			val_errors++;
		end
		if (req_rdy_o !== 1'b1) begin
			$display("FAILED at %0t ns: req_rdy_o expected 1, got %b", $time, req_rdy_o);
			val_errors++;
		end

		fd = $fopen("bench/mem_testdata.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open bench/mem_testdata.txt");
			other_errors++;
		end else begin
			while (!timed_out && !$feof(fd)) begin
				line = "";
				rc   = $fgets(line, fd);
				// Comment and blank lines carry no request
				if (rc > 0 && line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h",
						f_type, f_tag, f_addr, f_data, f_dom, f_exp, f_den, f_wait);
					if (n == 8) begin
						if (f_wait != 0)
							wait_drain();
						if (f_wait == 2 && !timed_out)
							pulse_clear();
						if (!timed_out)
							send_request(f_type[2:0], f_tag[OPAQUE_W-1:0], f_addr[ADDR_W-1:0],
								f_data, f_dom[0], f_exp, f_den[0]);
					end
				end
			end
			$fclose(fd);
			wait_drain();
		end
		report_and_finish();
	end

endmodule

// File: filelist.f
rtl/mem_pkg.sv
rtl/mem_chan_if.sv
rtl/mem_req_router.sv
rtl/mem_bank.sv
rtl/mem_resp_merge.sv
rtl/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// File: Makefile
# Verilator build and run for the banked test memory subsystem
# Run from the project root, the testbench opens bench/mem_testdata.txt

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
PASS_MSG  ?= ** PASS **

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mem_testdata.txt
# type opaque addr data domain exp_data exp_denied wait, all hex
# wait: 0 send at once, 1 drain first, 2 drain then pulse clear_i
1 01 0000 11111111 0 11111111 0 2
0 02 0000 00000000 0 11111111 0 0
1 03 0004 a0000001 0 a0000001 0 0
1 04 0008 a0000002 0 a0000002 0 0
1 05 000c a0000003 0 a0000003 0 0
1 06 0010 a0000004 0 a0000004 0 0
0 07 0004 00000000 0 a0000001 0 0
0 08 0008 00000000 0 a0000002 0 0
0 09 000c 00000000 0 a0000003 0 0
0 0a 0010 00000000 0 a0000004 0 0
3 0b 0000 00000010 0 11111111 0 0
0 0c 0000 00000000 0 11111121 0 0
4 0d 0000 0f0f0f0f 0 11111121 0 0
0 0e 0000 00000000 0 01010101 0 0
5 0f 0000 f0000000 0 01010101 0 0
0 10 0000 00000000 0 f1010101 0 0
3 11 0004 ffffffff 0 a0000001 0 0
0 12 0004 00000000 0 a0000000 0 0
1 13 0208 5ec00001 1 5ec00001 0 0
1 14 0208 deadbeef 0 00000000 1 0
0 15 0208 00000000 0 00000000 1 0
0 16 0208 00000000 1 5ec00001 0 0
3 17 0208 00000001 0 00000000 1 0
0 18 0008 00000000 1 a0000002 0 0
1 19 0018 cafe0001 1 cafe0001 0 0
0 1a 0018 00000000 0 cafe0001 0 0
0 1b 0000 00000000 0 00000000 0 2
0 1c 0208 00000000 1 00000000 0 0
0 1d 0010 00000000 0 00000000 0 0
0 1e 0018 00000000 0 00000000 0 0
